// ==== ddr_traffic_pkg.sv ====
// shared widths and types for a single chip DDR2 driver with burst length 1 and half-rate columns
package ddr_traffic_pkg;

  // --------------------
  // address and data widths
  // --------------------
  localparam int BANK_BITS  = 2;
  localparam int ROW_BITS   = 13;
  localparam int COL_BITS   = 9;
  localparam int DATA_BYTES = 16;
  localparam int DATA_BITS  = DATA_BYTES * 8;

  // column increment per access at half rate
  localparam int ADDR_STEP = 4;

  typedef struct packed {
    logic [BANK_BITS-1:0] bank;
    logic [ROW_BITS-1:0]  row;
    logic [COL_BITS-1:0]  col;
  } mem_addr_t;

  typedef logic [DATA_BITS-1:0]  data_word_t;
  typedef logic [DATA_BYTES-1:0] byte_en_t;

  typedef enum logic [1:0] {
    idle,
    seq_addr,
    dm_pin,
    addr_pin
  } test_mode_t;

  // --------------------
  // sequencer to execute stages
  // --------------------
  typedef struct packed {
    logic       write_req;
    logic       read_req;
    logic       reset_address;
    logic       reset_be;
    logic       reset_data;
    logic       dgen_load;
    logic       first_write;
    test_mode_t mode;
  } seq_ctrl_t;

endpackage

// ==== ddr_lfsr8.sv ====
// 8-bit maximal-length LFSR byte source where SEED must be nonzero and load wins over stepping
`timescale 1ns/1ps

module ddr_lfsr8 #(
  parameter logic [7:0] SEED = 8'd1
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       enable,
  input  logic       pause,
  input  logic       load,
  input  logic [7:0] ldata,
  output logic [7:0] data
);

  logic feedback;

  // taps 8 6 5 4 give the full 255 state cycle
  assign feedback = data[7] ^ data[5] ^ data[4] ^ data[3];

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      data <= SEED;
    else if (load)
      data <= ldata;
    else if (enable && !pause)
      data <= {data[6:0], feedback};
  end

endmodule

// ==== ddr_test_sequencer.sv ====
// test phase FSM that expects every wdata_req and rdata_valid to follow an accepted request
`timescale 1ns/1ps

module ddr_test_sequencer (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       local_ready,
  input  logic                       local_wdata_req,
  input  logic                       local_rdata_valid,
  input  logic                       reached_max,
  output ddr_traffic_pkg::seq_ctrl_t ctrl,
  output logic                       test_complete
);
  import ddr_traffic_pkg::*;

  typedef enum logic [3:0] {
    s_start,
    s_select,
    s_zero_write,
    s_zero_drain,
    s_reload,
    s_write,
    s_write_drain,
    s_read,
    s_read_drain,
    s_complete
  } seq_state_t;

  seq_state_t state;
  test_mode_t next_test;
  logic [7:0] writes_remaining;
  logic [7:0] reads_remaining;
  logic       write_accept;
  logic       read_accept;

  assign write_accept = ctrl.write_req & local_ready;
  assign read_accept  = ctrl.read_req & local_ready;

  // --------------------
  // outstanding counters
  // --------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      writes_remaining <= '0;
      reads_remaining  <= '0;
    end
    else if (state == s_select)
    begin
      writes_remaining <= '0;
      reads_remaining  <= '0;
    end
    else
    begin
      // accept and strobe in the same cycle cancel out
      if (write_accept && !local_wdata_req)
        writes_remaining <= writes_remaining + 8'd1;
      else if (!write_accept && local_wdata_req && writes_remaining != '0)
        writes_remaining <= writes_remaining - 8'd1;
      if (read_accept && !local_rdata_valid)
        reads_remaining <= reads_remaining + 8'd1;
      else if (!read_accept && local_rdata_valid && reads_remaining != '0)
        reads_remaining <= reads_remaining - 8'd1;
    end
  end

  // --------------------
  // phase machine
  // --------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= s_start;
      next_test     <= idle;
      ctrl          <= '0;
      test_complete <= 1'b0;
    end
    else
    begin
      case (state)
        s_start:
        begin
          next_test     <= seq_addr;
          test_complete <= 1'b0;
          state         <= s_select;
        end
        s_select:
        begin
          ctrl.reset_address <= 1'b0;
          ctrl.reset_be      <= 1'b0;
          ctrl.write_req     <= 1'b1;
          ctrl.first_write   <= 1'b1;
          ctrl.mode          <= next_test;
          // dm test starts by clearing every byte of the range
          if (next_test == dm_pin)
          begin
            ctrl.reset_data <= 1'b1;
            state           <= s_zero_write;
          end
          else
            state <= s_write;
        end
        s_zero_write:
        begin
          ctrl.first_write <= 1'b0;
          if (write_accept && reached_max)
          begin
            ctrl.write_req <= 1'b0;
            state          <= s_zero_drain;
          end
        end
        s_zero_drain:
        begin
          if (writes_remaining == '0)
          begin
            ctrl.reset_be      <= 1'b1;
            ctrl.reset_address <= 1'b1;
            ctrl.dgen_load     <= 1'b1;
            state              <= s_reload;
          end
        end
        s_reload:
        begin
          ctrl.reset_address <= 1'b0;
          ctrl.dgen_load     <= 1'b0;
          ctrl.reset_be      <= 1'b0;
          ctrl.reset_data    <= 1'b0;
          ctrl.write_req     <= 1'b1;
          state              <= s_write;
        end
        s_write:
        begin
          ctrl.first_write <= 1'b0;
          if (write_accept && reached_max)
          begin
            ctrl.reset_address <= 1'b1;
            ctrl.write_req     <= 1'b0;
            state              <= s_write_drain;
          end
        end
        s_write_drain:
        begin
          ctrl.reset_address <= 1'b0;
          if (writes_remaining == '0)
          begin
            ctrl.dgen_load <= 1'b1;
            ctrl.reset_be  <= 1'b1;
            ctrl.read_req  <= 1'b1;
            state          <= s_read;
          end
        end
        s_read:
        begin
          ctrl.dgen_load <= 1'b0;
          ctrl.reset_be  <= 1'b0;
          if (read_accept && reached_max)
          begin
            ctrl.read_req <= 1'b0;
            state         <= s_read_drain;
          end
        end
        s_read_drain:
        begin
          if (reads_remaining == '0)
          begin
            ctrl.reset_address <= 1'b1;
            ctrl.mode          <= idle;
            case (ctrl.mode)
              seq_addr:
              begin
                next_test <= dm_pin;
                state     <= s_select;
              end
              dm_pin:
              begin
                next_test <= addr_pin;
                state     <= s_select;
              end
              default:
              begin
                ctrl.dgen_load <= 1'b1;
                state          <= s_complete;
              end
            endcase
          end
        end
        s_complete:
        begin
          ctrl.reset_address <= 1'b0;
          ctrl.reset_be      <= 1'b0;
          ctrl.dgen_load     <= 1'b0;
          test_complete      <= 1'b1;
          state              <= s_start;
        end
        default:
          state <= s_start;
      endcase
    end
  end

  // write and read phases never overlap
  a_req_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
    !(ctrl.write_req && ctrl.read_req));

  // every strobe from the memory matches an earlier acceptance
  a_write_count: assert property (@(posedge clk) disable iff (!reset_n)
    local_wdata_req |-> writes_remaining != '0);
  a_read_count: assert property (@(posedge clk) disable iff (!reset_n)
    local_rdata_valid |-> reads_remaining != '0);

endmodule

// ==== ddr_addr_gen.sv ====
// address generator where MAX_COL must be a multiple of ADDR_STEP and walking covers all row bits
`timescale 1ns/1ps

module ddr_addr_gen #(
  parameter int MAX_ROW  = 3,
  parameter int MAX_COL  = 16,
  parameter int MAX_BANK = 3
) (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       local_ready,
  input  ddr_traffic_pkg::seq_ctrl_t ctrl,
  output ddr_traffic_pkg::mem_addr_t addr,
  output logic                       reached_max
);
  import ddr_traffic_pkg::*;

  localparam logic [ROW_BITS-1:0]  row_last   = ROW_BITS'(MAX_ROW);
  localparam logic [COL_BITS-1:0]  col_last   = COL_BITS'(MAX_COL);
  localparam logic [BANK_BITS-1:0] bank_last  = BANK_BITS'(MAX_BANK);
  localparam logic [ROW_BITS-1:0]  row_msb    = {1'b1, {(ROW_BITS-1){1'b0}}};
  localparam logic [ROW_BITS-1:0]  row_msb_lo = {1'b0, {(ROW_BITS-1){1'b1}}};

  mem_addr_t              seq_next;
  mem_addr_t              walk_next;
  logic [BANK_BITS-1:0]   bank_inc;
  logic                   advance;
  logic                   walk_mode;

  assign walk_mode = (ctrl.mode == dm_pin) || (ctrl.mode == addr_pin);
  assign advance   = local_ready && (ctrl.write_req || ctrl.read_req) && (ctrl.mode != idle);
  assign bank_inc  = (addr.bank == bank_last) ? '0 : addr.bank + 1'b1;

  // last address of the range for the current test
  assign reached_max = walk_mode ? (addr.row == '1) :
                       (ctrl.mode == seq_addr) && (addr.col == col_last) &&
                       (addr.row == row_last) && (addr.bank == bank_last);

  // --------------------
  // sequential stepping
  // --------------------
  always_comb
  begin
    seq_next = addr;
    if (addr.col >= col_last)
    begin
      seq_next.col = '0;
      if (addr.row == row_last)
      begin
        seq_next.row  = '0;
        seq_next.bank = bank_inc;
      end
      else
        seq_next.row = addr.row + 1'b1;
    end
    else
      seq_next.col = addr.col + COL_BITS'(ADDR_STEP);
  end

  // --------------------
  // walking one then walking zero
  // --------------------
  always_comb
  begin
    walk_next.bank = bank_inc;
    if (addr.row == '0)
    begin
      walk_next.row = ROW_BITS'(1);
      walk_next.col = COL_BITS'(4);
    end
    else if (addr.row == row_msb)
    begin
      // switch over to a walking zero
      walk_next.row = {{(ROW_BITS-1){1'b1}}, 1'b0};
      walk_next.col = {{(COL_BITS-3){1'b1}}, 3'b000};
    end
    else if (addr.row == row_msb_lo)
    begin
      walk_next.row = '1;
      walk_next.col = {{(COL_BITS-2){1'b1}}, 2'b00};
    end
    else
    begin
      walk_next.row = {addr.row[ROW_BITS-2:0], addr.row[ROW_BITS-1]};
      // low two column bits stay put
      walk_next.col = {addr.col[COL_BITS-2:2], addr.col[COL_BITS-1], addr.col[1:0]};
    end
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      addr <= '0;
    else if (ctrl.reset_address)
      addr <= '0;
    else if (advance)
      addr <= walk_mode ? walk_next : seq_next;
  end

endmodule

// ==== ddr_data_gen.sv ====
// write data and byte enable source where memory takes the word in its wdata_req cycle
`timescale 1ns/1ps

module ddr_data_gen (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        local_wdata_req,
  input  logic                        local_rdata_valid,
  input  ddr_traffic_pkg::seq_ctrl_t  ctrl,
  output ddr_traffic_pkg::data_word_t wdata,
  output ddr_traffic_pkg::data_word_t expected,
  output ddr_traffic_pkg::byte_en_t   be
);
  import ddr_traffic_pkg::*;

  data_word_t lfsr_data;
  data_word_t ldata;
  logic       lfsr_enable;
  logic       lfsr_pause;
  logic       dm_mode;
  logic       be_step;
  logic       be_all_ones;

  assign dm_mode = (ctrl.mode == dm_pin);

  // the zero pass does not consume the sequence
  assign lfsr_enable = ~ctrl.reset_data;
  assign lfsr_pause  = ~(local_wdata_req | local_rdata_valid);

  for (genvar lane = 0; lane < DATA_BYTES; lane++)
  begin : g_lane
    ddr_lfsr8 #(
      .SEED (8'(1 + 10 * lane))
    ) u_lfsr (
      .clk     (clk),
      .reset_n (reset_n),
      .enable  (lfsr_enable),
      .pause   (lfsr_pause),
      .load    (ctrl.dgen_load),
      .ldata   (ldata[8*lane +: 8]),
      .data    (lfsr_data[8*lane +: 8])
    );
  end

  // start of the write sequence, replayed for the read pass
  always_ff @(posedge clk)
  begin
    if (ctrl.first_write)
      ldata <= lfsr_data;
  end

  assign wdata    = ctrl.reset_data ? '0 : lfsr_data;
  assign expected = lfsr_data;

  // --------------------
  // byte enable rotator
  // --------------------
  assign be_step     = dm_mode && ((local_wdata_req && !ctrl.reset_data) || local_rdata_valid);
  assign be_all_ones = !dm_mode || ctrl.reset_data;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      be <= '1;
    else if (ctrl.reset_be)
      be <= byte_en_t'(1);
    else if (be_step)
      be <= {be[DATA_BYTES-2:0], be[DATA_BYTES-1]};
    else if (be_all_ones)
      be <= '1;
  end

  a_be_shape: assert property (@(posedge clk) disable iff (!reset_n)
    $onehot(be) || (&be));

endmodule

// ==== ddr_read_checker.sv ====
// read checker whose lane flags lag rdata_valid by 3 cycles and the persist flag by 4
`timescale 1ns/1ps

module ddr_read_checker (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        local_rdata_valid,
  input  ddr_traffic_pkg::data_word_t local_rdata,
  input  ddr_traffic_pkg::data_word_t expected,
  input  ddr_traffic_pkg::byte_en_t   be,
  output ddr_traffic_pkg::byte_en_t   pnf_per_byte,
  output logic                        pnf_persist
);
  import ddr_traffic_pkg::*;

  byte_en_t compare;
  byte_en_t compare_reg;
  byte_en_t compare_valid;
  logic     last_rdata_valid;
  logic     rdata_seen;
  logic     rdata_seen_d1;
  logic     rdata_seen_d2;
  logic     persist_pre;
  logic     persist_hold;

  // disabled lanes must read back the zeros written earlier
  always_comb
  begin
    for (int lane = 0; lane < DATA_BYTES; lane++)
      compare[lane] = ((expected[8*lane +: 8] & {8{be[lane]}}) == local_rdata[8*lane +: 8]);
  end

  assign persist_hold = rdata_seen_d2 ? persist_pre : 1'b1;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      compare_reg      <= '1;
      compare_valid    <= '1;
      pnf_per_byte     <= '1;
      last_rdata_valid <= 1'b0;
      rdata_seen       <= 1'b0;
      rdata_seen_d1    <= 1'b0;
      rdata_seen_d2    <= 1'b0;
      persist_pre      <= 1'b0;
      pnf_persist      <= 1'b0;
    end
    else
    begin
      compare_reg      <= compare;
      last_rdata_valid <= local_rdata_valid;
      if (local_rdata_valid)
        rdata_seen <= 1'b1;
      rdata_seen_d1 <= rdata_seen;
      rdata_seen_d2 <= rdata_seen_d1;
      // only returned words update the lane flags
      if (last_rdata_valid)
        compare_valid <= compare_reg;
      persist_pre  <= (&compare_valid) && rdata_seen_d1 && persist_hold;
      pnf_per_byte <= compare_valid;
      pnf_persist  <= persist_pre;
    end
  end

endmodule

// ==== ddr_traffic_driver.sv ====
// DDR2 local interface traffic driver with burst length 1 and one chip that loops its tests forever
`timescale 1ns/1ps

module ddr_traffic_driver #(
  parameter int MAX_ROW  = 3,
  parameter int MAX_COL  = 16,
  parameter int MAX_BANK = 3
) (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        local_ready,
  input  logic                        local_wdata_req,
  input  logic                        local_rdata_valid,
  input  ddr_traffic_pkg::data_word_t local_rdata,
  output ddr_traffic_pkg::mem_addr_t  local_addr,
  output logic                        local_write_req,
  output logic                        local_read_req,
  output ddr_traffic_pkg::data_word_t local_wdata,
  output ddr_traffic_pkg::byte_en_t   local_be,
  output ddr_traffic_pkg::byte_en_t   pnf_per_byte,
  output logic                        pnf_persist,
  output logic                        test_complete,
  output logic [7:0]                  test_status
);
  import ddr_traffic_pkg::*;

  seq_ctrl_t  ctrl;
  logic       reached_max;
  data_word_t expected;

  assign local_write_req = ctrl.write_req;
  assign local_read_req  = ctrl.read_req;

  // one bit per active test, complete on top
  assign test_status = {test_complete, 3'b000, ctrl.mode == addr_pin,
                        ctrl.mode == dm_pin, 1'b0, ctrl.mode == seq_addr};

  ddr_test_sequencer u_sequencer (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_wdata_req   (local_wdata_req),
    .local_rdata_valid (local_rdata_valid),
    .reached_max       (reached_max),
    .ctrl              (ctrl),
    .test_complete     (test_complete)
  );

  ddr_addr_gen #(
    .MAX_ROW  (MAX_ROW),
    .MAX_COL  (MAX_COL),
    .MAX_BANK (MAX_BANK)
  ) u_addr_gen (
    .clk         (clk),
    .reset_n     (reset_n),
    .local_ready (local_ready),
    .ctrl        (ctrl),
    .addr        (local_addr),
    .reached_max (reached_max)
  );

  ddr_data_gen u_data_gen (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_wdata_req   (local_wdata_req),
    .local_rdata_valid (local_rdata_valid),
    .ctrl              (ctrl),
    .wdata             (local_wdata),
    .expected          (expected),
    .be                (local_be)
  );

  ddr_read_checker u_read_checker (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_rdata_valid (local_rdata_valid),
    .local_rdata       (local_rdata),
    .expected          (expected),
    .be                (local_be),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist)
  );

endmodule

// ==== tb_ddr_mem_model.sv ====
// local interface memory model with burst length 1, in-order reads and a read latency of 1 or more
`timescale 1ns/1ps

module tb_ddr_mem_model (
  input  logic                        clk,
  input  logic                        reset_n,
  input  int                          ready_pct,
  input  int                          lat_min,
  input  int                          lat_max,
  input  int                          bad_lane,
  input  ddr_traffic_pkg::mem_addr_t  local_addr,
  input  logic                        local_write_req,
  input  logic                        local_read_req,
  input  ddr_traffic_pkg::data_word_t local_wdata,
  input  ddr_traffic_pkg::byte_en_t   local_be,
  output logic                        local_ready,
  output logic                        local_wdata_req,
  output ddr_traffic_pkg::data_word_t local_rdata,
  output logic                        local_rdata_valid,
  output int                          errors
);
  import ddr_traffic_pkg::*;

  typedef struct packed {
    mem_addr_t addr;
    int        due;
  } read_entry_t;

  data_word_t  store [logic [$bits(mem_addr_t)-1:0]];
  mem_addr_t   write_q [$];
  read_entry_t read_q [$];

  logic       ready_q  = 1'b0;
  logic       wreq_q   = 1'b0;
  logic       rvalid_q = 1'b0;
  data_word_t rdata_q  = '0;
  int         error_q  = 0;
  int         cycle    = 0;
  logic       seeded   = 1'b0;
  data_word_t word;
  int         lat;

  assign local_ready       = ready_q;
  assign local_wdata_req   = wreq_q;
  assign local_rdata       = rdata_q;
  assign local_rdata_valid = rvalid_q;
  assign errors            = error_q;

  always @(posedge clk)
  begin
    // fixed seed for the ready and latency draws
    if (!seeded)
    begin
      void'($urandom(90));
      seeded = 1'b1;
    end
    if (!reset_n)
    begin
      store.delete();
      write_q.delete();
      read_q.delete();
      ready_q  <= 1'b0;
      wreq_q   <= 1'b0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      cycle++;
      if (local_write_req && local_read_req)
      begin
        $display("memory model: write and read requests high together at %0t", $time);
        error_q++;
      end
      // --------------------
      // strobe cycle takes data for the oldest accepted write
      if (wreq_q && write_q.size() != 0)
      begin
        word = store.exists(write_q[0]) ? store[write_q[0]] : '0;
        for (int lane = 0; lane < DATA_BYTES; lane++)
          if (local_be[lane])
            word[8*lane +: 8] = local_wdata[8*lane +: 8];
        store[write_q[0]] = word;
        void'(write_q.pop_front());
      end
      if (local_write_req && ready_q)
        write_q.push_back(local_addr);
      if (local_read_req && ready_q)
      begin
        lat = $urandom_range(lat_max, lat_min);
        read_q.push_back('{local_addr, cycle + lat});
      end
      wreq_q <= (write_q.size() != 0);
      // --------------------
      // reads return in request order once their latency is over
      if (read_q.size() != 0 && read_q[0].due <= cycle)
      begin
        if (store.exists(read_q[0].addr))
          word = store[read_q[0].addr];
        else
        begin
          $display("memory model: read of unwritten address %h at %0t", read_q[0].addr, $time);
          error_q++;
          word = '0;
        end
        if (bad_lane < DATA_BYTES)
          word[8*bad_lane +: 8] = ~word[8*bad_lane +: 8];
        rdata_q  <= word;
        rvalid_q <= 1'b1;
        void'(read_q.pop_front());
      end
      else
        rvalid_q <= 1'b0;
      ready_q <= ($urandom_range(99) < ready_pct);
    end
  end

endmodule

// ==== tb_ddr_traffic_driver.sv ====
// testbench for the default 4x4x5 sequential range where each table row runs two full test loops
`timescale 1ns/1ps

module tb_ddr_traffic_driver;
  import ddr_traffic_pkg::*;

  localparam int max_row        = 3;
  localparam int max_col        = 16;
  localparam int max_bank       = 3;
  localparam int addr_step      = 4;
  localparam int seq_accesses   = (max_row + 1) * (max_bank + 1) * (max_col / addr_step + 1);
  localparam int loops_per_row  = 2;
  localparam int timeout_cycles = 20000;
  localparam int no_lane        = 16;
  localparam int num_rows       = 4;

  typedef struct packed {
    int          ready_pct;
    int          lat_min;
    int          lat_max;
    int          bad_lane;
    logic        exp_persist;
    logic [15:0] exp_pnf;
  } stim_row_t;

  // ready %, latency min and max, corrupted lane, pnf_persist, pnf_per_byte
  stim_row_t stim_table [num_rows] = '{
    '{100, 1, 1, no_lane, 1'b1, 16'hffff},
    '{30,  2, 8, no_lane, 1'b1, 16'hffff},
    '{70,  1, 5, 5,       1'b0, 16'hffdf},
    '{85,  3, 3, 12,      1'b0, 16'hefff}
  };

  logic       clk       = 1'b0;
  logic       reset_n   = 1'b0;
  int         ready_pct = 0;
  int         lat_min   = 1;
  int         lat_max   = 1;
  int         bad_lane  = no_lane;
  logic       local_ready;
  logic       local_wdata_req;
  logic       local_rdata_valid;
  data_word_t local_rdata;
  mem_addr_t  local_addr;
  logic       local_write_req;
  logic       local_read_req;
  data_word_t local_wdata;
  byte_en_t   local_be;
  byte_en_t   pnf_per_byte;
  logic       pnf_persist;
  logic       test_complete;
  logic [7:0] test_status;
  int         model_errors;

  int         error_count = 0;
  int         seq_writes;
  int         seq_reads;
  logic [3:0] mode_log [$];
  logic       timed_out = 1'b0;

  always #5 clk = ~clk;

  ddr_traffic_driver #(
    .MAX_ROW  (max_row),
    .MAX_COL  (max_col),
    .MAX_BANK (max_bank)
  ) uut (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_wdata_req   (local_wdata_req),
    .local_rdata_valid (local_rdata_valid),
    .local_rdata       (local_rdata),
    .local_addr        (local_addr),
    .local_write_req   (local_write_req),
    .local_read_req    (local_read_req),
    .local_wdata       (local_wdata),
    .local_be          (local_be),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist),
    .test_complete     (test_complete),
    .test_status       (test_status)
  );

  tb_ddr_mem_model mem (
    .clk               (clk),
    .reset_n           (reset_n),
    .ready_pct         (ready_pct),
    .lat_min           (lat_min),
    .lat_max           (lat_max),
    .bad_lane          (bad_lane),
    .local_addr        (local_addr),
    .local_write_req   (local_write_req),
    .local_read_req    (local_read_req),
    .local_wdata       (local_wdata),
    .local_be          (local_be),
    .local_ready       (local_ready),
    .local_wdata_req   (local_wdata_req),
    .local_rdata       (local_rdata),
    .local_rdata_valid (local_rdata_valid),
    .errors            (model_errors)
  );

  task check(input string name, input logic [127:0] actual, input logic [127:0] expected);
    if (actual !== expected)
    begin
      error_count++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  // --------------------
  // reset with new model settings
  // --------------------
  task apply_reset(input stim_row_t row);
    @(posedge clk);
    reset_n   <= 1'b0;
    ready_pct <= row.ready_pct;
    lat_min   <= row.lat_min;
    lat_max   <= row.lat_max;
    bad_lane  <= row.bad_lane;
    repeat (10) @(posedge clk);
    reset_n <= 1'b1;
    // first cycle after release
    @(posedge clk);
    check("local_write_req", local_write_req, 1'b0);
    check("local_read_req", local_read_req, 1'b0);
    check("test_complete", test_complete, 1'b0);
  endtask

  // follows the modes and counts seq accesses until the complete pulse
  task wait_for_complete(output logic hit_timeout);
    int         cycles;
    logic [3:0] mode_bits;
    logic [3:0] last_mode;
    hit_timeout = 1'b1;
    cycles      = 0;
    last_mode   = 4'h0;
    seq_writes  = 0;
    seq_reads   = 0;
    mode_log.delete();
    while (hit_timeout && cycles < timeout_cycles)
    begin
      @(posedge clk);
      cycles++;
      mode_bits = test_status[3:0];
      if (mode_bits != 4'h0 && mode_bits != last_mode)
        mode_log.push_back(mode_bits);
      last_mode = mode_bits;
      if (test_status[0] && local_ready)
      begin
        if (local_write_req)
          seq_writes++;
        if (local_read_req)
          seq_reads++;
      end
      if (test_complete)
        hit_timeout = 1'b0;
    end
  endtask

  task check_loop(input stim_row_t row);
    check("test_status", test_status, 8'h80);
    check("pnf_per_byte", pnf_per_byte, row.exp_pnf);
    check("seq_write_count", seq_writes, seq_accesses);
    check("seq_read_count", seq_reads, seq_accesses);
    check("test_status_mode_count", mode_log.size(), 3);
    // seq, then dm, then addr-pin
    if (mode_log.size() == 3)
      check("test_status_mode_order", {mode_log[0], mode_log[1], mode_log[2]}, 12'h148);
    @(posedge clk);
    check("pnf_persist", pnf_persist, row.exp_persist);
  endtask

  initial
  begin
    for (int r = 0; r < num_rows && !timed_out; r++)
    begin
      apply_reset(stim_table[r]);
      for (int l = 0; l < loops_per_row && !timed_out; l++)
      begin
        wait_for_complete(timed_out);
        if (timed_out)
        begin
          error_count++;
          $display("timeout: no test_complete within %0d cycles in table row %0d",
                   timeout_cycles, r);
        end
        else
          check_loop(stim_table[r]);
      end
    end
    $display("summary: %0d check errors, %0d memory model errors", error_count, model_errors);
    if (error_count == 0 && model_errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== ddr_traffic_driver.f ====
ddr_traffic_pkg.sv
ddr_lfsr8.sv
ddr_test_sequencer.sv
ddr_addr_gen.sv
ddr_data_gen.sv
ddr_read_checker.sv
ddr_traffic_driver.sv
tb_ddr_mem_model.sv
tb_ddr_traffic_driver.sv
